//--- Makefile
# Verilator build and run of the UMI remap testbench
# a failing run ends in $fatal, which gives a nonzero exit status

VERILATOR ?= verilator
TOP       ?= umi_remap_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- flist.f
hdl/umi_remap_pkg.sv
hdl/umi_remap_regs.sv
hdl/umi_remap_lookup.sv
hdl/umi_address_remap.sv
hdl/umi_remap_top.sv
tests/umi_remap_tb.sv

//--- hdl/umi_address_remap.sv
// umi address remap, stage 2 that builds the final dstaddr into the output slot
module umi_address_remap (
    input  logic                              clk,
    input  logic                              rst_n,
    // from stage 1
    input  logic                              dec_valid,
    input  umi_remap_pkg::umi_dec_t           dec,
    output logic                              dec_ready,
    // window offset, sampled here
    input  logic [umi_remap_pkg::umi_aw-1:0]  cfg_offset,
    // UMI out
    output logic                              out_valid,
    output umi_remap_pkg::umi_txn_t           out_txn,
    input  logic                              out_ready
);
    import umi_remap_pkg::*;

    umi_addr_u new_addr;  // rewritten dstaddr

    // window subtract on the flat view, chip id splice on the field view
    always_comb begin
        new_addr = dec.txn.dstaddr;
        if (dec.win_hit) begin
            new_addr.flat = dec.txn.dstaddr.flat - cfg_offset;  // wraps like the hw adder
        end else if (dec.map_hit) begin
            new_addr.f.chipid = dec.new_id;  // bits 55:40 only
        end
    end

    // output slot
    assign dec_ready = ~out_valid | out_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (dec_ready) begin
            out_valid <= dec_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (dec_ready && dec_valid) begin
            out_txn.cmd     <= dec.txn.cmd;      // passthrough
            out_txn.dstaddr <= new_addr;
            out_txn.srcaddr <= dec.txn.srcaddr;  // passthrough
            out_txn.data    <= dec.txn.data;     // passthrough
        end
    end

    // UMI rule on the output, valid holds with stable payload until taken
    a_out_hold: assert property (
        @(posedge clk) disable iff (!rst_n)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_txn))
    );

    // stage 1 gives the window priority, so the flags are exclusive
    a_flags_excl: assert property (
        @(posedge clk) disable iff (!rst_n)
        dec_valid |-> !(dec.win_hit && dec.map_hit)
    );

endmodule

//--- hdl/umi_remap_lookup.sv
// umi remap lookup, stage 1 that finds window or table hits and registers the decision
module umi_remap_lookup #(
    parameter int NMAPS = 4
) (
    input  logic                               clk,
    input  logic                               rst_n,
    // UMI in
    input  logic                               in_valid,
    input  umi_remap_pkg::umi_txn_t            in_txn,
    output logic                               in_ready,
    // configuration, sampled on entry
    input  logic [umi_remap_pkg::umi_idw-1:0]  cfg_chipid,
    input  logic [NMAPS-1:0]                   cfg_map_en,
    input  logic [umi_remap_pkg::umi_idw-1:0]  cfg_map_old [NMAPS],
    input  logic [umi_remap_pkg::umi_idw-1:0]  cfg_map_new [NMAPS],
    input  logic [umi_remap_pkg::umi_aw-1:0]   cfg_win_low,
    input  logic [umi_remap_pkg::umi_aw-1:0]   cfg_win_high,
    // to stage 2
    output logic                               dec_valid,
    output umi_remap_pkg::umi_dec_t            dec,
    input  logic                               dec_ready
);
    import umi_remap_pkg::*;

    logic [umi_idw-1:0] in_id;      // chip id field of dstaddr
    logic               win_hit;
    logic               local_hit;  // field is our own chip
    logic [NMAPS-1:0]   map_match;  // per entry compare
    logic               map_any;
    logic [umi_idw-1:0] map_id;     // new id of lowest match
    logic               remap_hit;

    assign in_id = in_txn.dstaddr.f.chipid;

    // window bounds are inclusive, both compares in parallel
    assign win_hit = (in_txn.dstaddr.flat >= cfg_win_low) &&
                     (in_txn.dstaddr.flat <= cfg_win_high);

    assign local_hit = (in_id == cfg_chipid);

    always_comb begin
        for (int i = 0; i < NMAPS; i++) begin
            map_match[i] = cfg_map_en[i] && (cfg_map_old[i] == in_id);
        end
    end

    // priority search, walk down so the lowest index is left standing
    always_comb begin
        map_any = 1'b0;
        map_id  = in_id;
        for (int i = NMAPS - 1; i >= 0; i--) begin
            if (map_match[i]) begin
                map_any = 1'b1;
                map_id  = cfg_map_new[i];
            end
        end
    end

    // window wins, local chip id is never remapped
    assign remap_hit = map_any & ~win_hit & ~local_hit;

    // single slot, ready when empty or draining
    assign in_ready = ~dec_valid | dec_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dec_valid <= 1'b0;
        end else if (in_ready) begin
            dec_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_ready && in_valid) begin
            dec.txn     <= in_txn;
            dec.win_hit <= win_hit;
            dec.map_hit <= remap_hit;
            dec.new_id  <= map_id;
        end
    end

    // held decision must not move until stage 2 takes it
    a_dec_hold: assert property (
        @(posedge clk) disable iff (!rst_n)
        (dec_valid && !dec_ready) |=> (dec_valid && $stable(dec))
    );

endmodule

//--- hdl/umi_remap_pkg.sv
// umi remap package, UMI widths, address views and the pipeline payload types
package umi_remap_pkg;

    // UMI widths, fixed for this subsystem
    localparam int umi_cw   = 32;   // command
    localparam int umi_aw   = 64;   // address
    localparam int umi_dw   = 128;  // data
    localparam int umi_idw  = 16;   // chip id field
    localparam int umi_idsb = 40;   // chip id start bit, 1 TiB per chiplet

    // APB side
    localparam int apb_aw = 12;
    localparam int apb_dw = 32;

    // register map, byte offsets
    localparam logic [apb_aw-1:0] reg_chipid      = 12'h000;
    localparam logic [apb_aw-1:0] reg_map_en      = 12'h004;  // entry enable mask
    localparam logic [apb_aw-1:0] reg_win_low_lo  = 12'h010;
    localparam logic [apb_aw-1:0] reg_win_low_hi  = 12'h014;
    localparam logic [apb_aw-1:0] reg_win_high_lo = 12'h018;
    localparam logic [apb_aw-1:0] reg_win_high_hi = 12'h01C;
    localparam logic [apb_aw-1:0] reg_offset_lo   = 12'h020;
    localparam logic [apb_aw-1:0] reg_offset_hi   = 12'h024;
    localparam logic [apb_aw-1:0] reg_map_base    = 12'h100;  // entry i at base + 4i

    // one address word, read flat for compare/subtract or by field for the chip id
    typedef union packed {
        logic [umi_aw-1:0] flat;
        struct packed {
            logic [umi_aw-umi_idsb-umi_idw-1:0] upper;      // bits 63:56
            logic [umi_idw-1:0]                 chipid;     // bits 55:40
            logic [umi_idsb-1:0]                local_addr; // offset inside chiplet
        } f;
    } umi_addr_u;

    // one UMI transaction as it travels through the pipe
    typedef struct packed {
        logic [umi_cw-1:0] cmd;
        umi_addr_u         dstaddr;
        logic [umi_aw-1:0] srcaddr;
        logic [umi_dw-1:0] data;
    } umi_txn_t;

    // stage 1 -> stage 2 payload
    typedef struct packed {
        umi_txn_t           txn;
        logic               win_hit;  // dstaddr inside window, subtract offset
        logic               map_hit;  // table match, splice new_id
        logic [umi_idw-1:0] new_id;   // replacement chip id
    } umi_dec_t;

endpackage

//--- hdl/umi_remap_regs.sv
// umi remap register file, APB slave holding chipid, window, offset and remap table
module umi_remap_regs #(
    parameter int NMAPS = 4
) (
    input  logic                               clk,
    input  logic                               rst_n,
    // APB slave
    input  logic                               psel,
    input  logic                               penable,
    input  logic                               pwrite,
    input  logic [umi_remap_pkg::apb_aw-1:0]   paddr,
    input  logic [umi_remap_pkg::apb_dw-1:0]   pwdata,
    output logic [umi_remap_pkg::apb_dw-1:0]   prdata,
    output logic                               pready,
    output logic                               pslverr,
    // configuration out
    output logic [umi_remap_pkg::umi_idw-1:0]  cfg_chipid,
    output logic [NMAPS-1:0]                   cfg_map_en,
    output logic [umi_remap_pkg::umi_idw-1:0]  cfg_map_old [NMAPS],
    output logic [umi_remap_pkg::umi_idw-1:0]  cfg_map_new [NMAPS],
    output logic [umi_remap_pkg::umi_aw-1:0]   cfg_win_low,
    output logic [umi_remap_pkg::umi_aw-1:0]   cfg_win_high,
    output logic [umi_remap_pkg::umi_aw-1:0]   cfg_offset
);
    import umi_remap_pkg::*;

    localparam int map_iw = (NMAPS > 1) ? $clog2(NMAPS) : 1;  // entry index width

    logic                    wr_en;       // access phase write
    logic [apb_aw-1:0]       map_off;     // offset from table base
    logic [apb_aw-3:0]       map_idx;     // word index from table base
    logic [map_iw-1:0]       map_ent;     // entry index, array width
    logic                    map_sel;     // valid entry address
    logic                    addr_ok;     // offset is mapped
    logic [NMAPS+apb_dw-1:0] en_wr_ext;   // pwdata padded up to NMAPS bits
    logic [NMAPS+apb_dw-1:0] en_rd_ext;   // enable mask padded up to apb_dw bits

    assign pready = 1'b1;  // no wait states
    assign wr_en  = psel & penable & pwrite;

    // table decode, any depth
    assign map_off = paddr - reg_map_base;
    assign map_idx = map_off[apb_aw-1:2];
    assign map_ent = map_idx[map_iw-1:0];
    assign map_sel = (paddr >= reg_map_base) && (map_off[1:0] == 2'b00) &&
                     (int'(map_idx) < NMAPS);

    assign en_wr_ext = {{NMAPS{1'b0}}, pwdata};
    assign en_rd_ext = {{apb_dw{1'b0}}, cfg_map_en};

    // register writes, take effect on the access cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cfg_chipid   <= '0;
            cfg_map_en   <= '0;
            cfg_win_low  <= '0;
            cfg_win_high <= '0;
            cfg_offset   <= '0;
            for (int i = 0; i < NMAPS; i++) begin
                cfg_map_old[i] <= '0;
                cfg_map_new[i] <= '0;
            end
        end else if (wr_en && addr_ok) begin
            if (map_sel) begin
                cfg_map_old[map_ent] <= pwdata[umi_idw-1:0];          // old id low half
                cfg_map_new[map_ent] <= pwdata[2*umi_idw-1:umi_idw];  // new id high half
            end else begin
                case (paddr)
                    reg_chipid:      cfg_chipid <= pwdata[umi_idw-1:0];
                    reg_map_en:      cfg_map_en <= en_wr_ext[NMAPS-1:0];
                    reg_win_low_lo:  cfg_win_low[apb_dw-1:0]       <= pwdata;
                    reg_win_low_hi:  cfg_win_low[umi_aw-1:apb_dw]  <= pwdata;
                    reg_win_high_lo: cfg_win_high[apb_dw-1:0]      <= pwdata;
                    reg_win_high_hi: cfg_win_high[umi_aw-1:apb_dw] <= pwdata;
                    reg_offset_lo:   cfg_offset[apb_dw-1:0]        <= pwdata;
                    reg_offset_hi:   cfg_offset[umi_aw-1:apb_dw]   <= pwdata;
                    default: ;  // unmapped, already flagged
                endcase
            end
        end
    end

    // read mux, combinational so prdata is ready in the access cycle
    always_comb begin
        prdata  = '0;
        addr_ok = 1'b1;
        if (map_sel) begin
            prdata = {cfg_map_new[map_ent], cfg_map_old[map_ent]};
        end else begin
            case (paddr)
                reg_chipid:      prdata[umi_idw-1:0] = cfg_chipid;
                reg_map_en:      prdata = en_rd_ext[apb_dw-1:0];
                reg_win_low_lo:  prdata = cfg_win_low[apb_dw-1:0];
                reg_win_low_hi:  prdata = cfg_win_low[umi_aw-1:apb_dw];
                reg_win_high_lo: prdata = cfg_win_high[apb_dw-1:0];
                reg_win_high_hi: prdata = cfg_win_high[umi_aw-1:apb_dw];
                reg_offset_lo:   prdata = cfg_offset[apb_dw-1:0];
                reg_offset_hi:   prdata = cfg_offset[umi_aw-1:apb_dw];
                default:         addr_ok = 1'b0;  // hole or entry past NMAPS
            endcase
        end
    end

    assign pslverr = psel & penable & ~addr_ok;

    // APB master behaviour
    a_paddr_aligned: assert property (
        @(posedge clk) disable iff (!rst_n)
        psel |-> (paddr[1:0] == 2'b00)
    );

    // access phase always follows a setup phase with psel
    a_penable_psel: assert property (
        @(posedge clk) disable iff (!rst_n)
        $rose(penable) |-> psel
    );

endmodule

//--- hdl/umi_remap_top.sv
// umi remap top, APB configured two-stage dstaddr rewrite between chiplets
module umi_remap_top #(
    parameter int NMAPS = 4
) (
    input  logic                              clk,
    input  logic                              rst_n,
    // APB slave
    input  logic                              psel,
    input  logic                              penable,
    input  logic                              pwrite,
    input  logic [umi_remap_pkg::apb_aw-1:0]  paddr,
    input  logic [umi_remap_pkg::apb_dw-1:0]  pwdata,
    output logic [umi_remap_pkg::apb_dw-1:0]  prdata,
    output logic                              pready,
    output logic                              pslverr,
    // UMI in
    input  logic                              in_valid,
    input  umi_remap_pkg::umi_txn_t           in_txn,
    output logic                              in_ready,
    // UMI out
    output logic                              out_valid,
    output umi_remap_pkg::umi_txn_t           out_txn,
    input  logic                              out_ready
);
    import umi_remap_pkg::*;

    // configuration
    logic [umi_idw-1:0] cfg_chipid;
    logic [NMAPS-1:0]   cfg_map_en;
    logic [umi_idw-1:0] cfg_map_old [NMAPS];
    logic [umi_idw-1:0] cfg_map_new [NMAPS];
    logic [umi_aw-1:0]  cfg_win_low;
    logic [umi_aw-1:0]  cfg_win_high;
    logic [umi_aw-1:0]  cfg_offset;

    // stage 1 -> stage 2
    logic     dec_valid;
    umi_dec_t dec;
    logic     dec_ready;

    umi_remap_regs #(.NMAPS(NMAPS)) i_umi_remap_regs (
        .clk, .rst_n,
        .psel, .penable, .pwrite, .paddr, .pwdata, .prdata, .pready, .pslverr,
        .cfg_chipid, .cfg_map_en, .cfg_map_old, .cfg_map_new,
        .cfg_win_low, .cfg_win_high, .cfg_offset
    );

    umi_remap_lookup #(.NMAPS(NMAPS)) i_umi_remap_lookup (
        .clk, .rst_n,
        .in_valid, .in_txn, .in_ready,
        .cfg_chipid, .cfg_map_en, .cfg_map_old, .cfg_map_new,
        .cfg_win_low, .cfg_win_high,
        .dec_valid, .dec, .dec_ready
    );

    umi_address_remap i_umi_address_remap (
        .clk, .rst_n,
        .dec_valid, .dec, .dec_ready,
        .cfg_offset,
        .out_valid, .out_txn, .out_ready
    );

endmodule

//--- tests/umi_remap_golden.txt
# W offset data | R offset expected_data expected_slverr (all hex)
# T name cmd dstaddr srcaddr data expected_dstaddr (all hex after the name)
# reset state, registers read zero and a transaction passes unchanged
R 000 00000000 0
R 004 00000000 0
R 010 00000000 0
R 01c 00000000 0
R 024 00000000 0
R 100 00000000 0
T reset_pass 00000011 0012345678abcdef 1000 00112233445566778899aabbccddeeff 0012345678abcdef
# chipid 0x0012, all entries on, window inside chip 0x0021, offset one chip down
W 000 00000012
W 004 0000000f
W 010 00001000
W 014 00002100
W 018 00001fff
W 01c 00002100
W 020 00000000
W 024 00000100
W 100 00a10021
W 104 00b20012
W 108 00c30033
W 10c 00d40033
R 000 00000012 0
R 004 0000000f 0
R 010 00001000 0
R 014 00002100 0
R 018 00001fff 0
R 01c 00002100 0
R 020 00000000 0
R 024 00000100 0
R 100 00a10021 0
R 104 00b20012 0
R 108 00c30033 0
R 10c 00d40033 0
# unmapped hole, then entry index NMAPS
R 008 00000000 1
R 110 00000000 1
# chip id and table
T local_id 00000021 0000120000000abc 2000 beef 0000120000000abc
T upper_kept 00000022 5a0021123456789a 2000 beef 5a00a1123456789a
T no_entry 00000023 0000770000000100 2000 beef 0000770000000100
T lowest_idx 00000024 0000330000000200 2000 beef 0000c30000000200
W 004 0000000b
T skip_off 00000025 0000330000000300 2000 beef 0000d40000000300
W 004 00000003
T both_off 00000026 0000330000000400 2000 beef 0000330000000400
W 004 0000000f
# window bounds, low and high hit, low-1 and high+1 fall to the table
T win_low 00000031 0000210000001000 3000 cafe 0000200000001000
T win_high 00000032 0000210000001fff 3000 cafe 0000200000001fff
T below_low 00000033 0000210000000fff 3000 cafe 0000a10000000fff
T above_high 00000034 0000210000002000 3000 cafe 0000a10000002000
# burst under random out_ready
T burst_0 a0000001 0000210000001800 11111111 000102030405060708090a0b0c0d0e0f 0000200000001800
T burst_1 a0000002 0000330000000004 22222222 101112131415161718191a1b1c1d1e1f 0000c30000000004
T burst_2 a0000003 0000120000000008 33333333 202122232425262728292a2b2c2d2e2f 0000120000000008
T burst_3 a0000004 0000770000000010 44444444 303132333435363738393a3b3c3d3e3f 0000770000000010
T burst_4 a0000005 ff00210000000020 55555555 404142434445464748494a4b4c4d4e4f ff00a10000000020
T burst_5 a0000006 0000210000001fff 66666666 505152535455565758595a5b5c5d5e5f 0000200000001fff
T burst_6 a0000007 0000a10000000040 77777777 606162636465666768696a6b6c6d6e6f 0000a10000000040
T burst_7 a0000008 0000210000000080 88888888 707172737475767778797a7b7c7d7e7f 0000a10000000080

//--- tests/umi_remap_tb.sv
// umi remap testbench, golden file driven APB setup and UMI checks under random back-pressure
module umi_remap_tb;
    import umi_remap_pkg::*;

    localparam int n_maps     = 4;
    localparam int wait_limit = 2000;  // cycles allowed per wait loop
    localparam int settle     = 5;     // mid low phase, after falling edge drives settle

    logic              clk;
    logic              rst_n;
    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [apb_aw-1:0] paddr;
    logic [apb_dw-1:0] pwdata;
    logic [apb_dw-1:0] prdata;
    logic              pready;
    logic              pslverr;
    logic              in_valid;
    umi_txn_t          in_txn;
    logic              in_ready;
    logic              out_valid;
    umi_txn_t          out_txn;
    logic              out_ready;

    umi_txn_t exp_q[$];   // expected outputs, in order
    string    name_q[$];  // test name per expected output
    int       sent;

    umi_remap_top #(.NMAPS(n_maps)) i_umi_remap_top (
        .clk, .rst_n,
        .psel, .penable, .pwrite, .paddr, .pwdata, .prdata, .pready, .pslverr,
        .in_valid, .in_txn, .in_ready,
        .out_valid, .out_txn, .out_ready
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;  // period 20
    end

    // one galois step, lsb out
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        logic [31:0] next;
        next = state >> 1;
        if (state[0]) begin
            next = next ^ 32'h8020_0003;  // feedback mask
        end
        return next;
    endfunction

    task automatic stop_on_error(input string why);
        $display("%s", why);
        $display("FAIL: see errors above");
        $fatal(1, "run stopped at first error");
    endtask

    // one APB transfer, setup then access, called on a falling edge
    task automatic apb_access(input logic write, input logic [apb_aw-1:0] addr,
                              input logic [apb_dw-1:0] wdata,
                              output logic [apb_dw-1:0] rdata, output logic err);
        int   waited;
        logic done;
        waited  = 0;
        done    = 1'b0;
        psel    = 1'b1;  // setup
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge clk);
        penable = 1'b1;  // access
        while (!done) begin
            #settle;
            done  = pready;   // access completes on this edge
            rdata = prdata;
            err   = pslverr;
            @(negedge clk);
            waited++;
            assert (done || waited < wait_limit)
                else stop_on_error("timeout waiting for pready on the APB access");
        end
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    // hold valid and data until the rising edge that takes them
    task automatic send_txn(input umi_txn_t txn);
        int   waited;
        logic taken;
        waited   = 0;
        taken    = 1'b0;
        in_valid = 1'b1;
        in_txn   = txn;
        while (!taken) begin
            #settle;
            taken = in_ready;  // accepted at the coming rising edge
            @(negedge clk);
            waited++;
            assert (taken || waited < wait_limit)
                else stop_on_error("timeout waiting for in_ready");
        end
        in_valid = 1'b0;
    endtask

    // pipeline idle before any config access
    task automatic drain_pipe();
        int waited;
        waited = 0;
        #settle;
        while (exp_q.size() != 0) begin
            @(negedge clk);
            #settle;
            waited++;
            assert (waited < wait_limit)
                else stop_on_error("timeout waiting for the pipeline to drain");
        end
        @(negedge clk);
    endtask

    // out_ready from the lfsr, compare each transfer against the queue head
    initial begin : out_monitor
        umi_txn_t    exp_txn;
        string       name;
        logic        rdy;
        logic [31:0] lfsr;
        out_ready = 1'b0;
        lfsr      = 32'h2568_79c7;
        forever begin
            @(negedge clk);
            rdy       = lfsr[0];  // one bit per cycle
            lfsr      = lfsr_step(lfsr);
            out_ready = rdy;
            if (out_valid && rdy) begin  // transfer at the coming rising edge
                assert (exp_q.size() > 0)
                    else stop_on_error("output transfer arrived with nothing expected");
                exp_txn = exp_q.pop_front();
                name    = name_q.pop_front();
                assert (out_txn.dstaddr.flat == exp_txn.dstaddr.flat)
                    else stop_on_error($sformatf("Error: %s dstaddr expected %h actual %h",
                        name, exp_txn.dstaddr.flat, out_txn.dstaddr.flat));
                assert (out_txn.cmd == exp_txn.cmd)
                    else stop_on_error($sformatf("Error: %s cmd expected %h actual %h",
                        name, exp_txn.cmd, out_txn.cmd));
                assert (out_txn.srcaddr == exp_txn.srcaddr)
                    else stop_on_error($sformatf("Error: %s srcaddr expected %h actual %h",
                        name, exp_txn.srcaddr, out_txn.srcaddr));
                assert (out_txn.data == exp_txn.data)
                    else stop_on_error($sformatf("Error: %s data expected %h actual %h",
                        name, exp_txn.data, out_txn.data));
            end
        end
    end

    initial begin : main
        int                fd;
        int                n;
        string             op;
        string             name;
        string             skip;
        logic [apb_aw-1:0] off;
        logic [apb_dw-1:0] wdata;
        logic [apb_dw-1:0] exp_rdata;
        logic [apb_dw-1:0] rdata;
        logic              exp_err;
        logic              err;
        logic [umi_cw-1:0] cmd;
        logic [umi_aw-1:0] dst;
        logic [umi_aw-1:0] src;
        logic [umi_dw-1:0] data;
        logic [umi_aw-1:0] exp_dst;
        umi_txn_t          txn;
        umi_txn_t          exp_txn;
        rst_n    = 1'b0;
        psel     = 1'b0;
        penable  = 1'b0;
        pwrite   = 1'b0;
        paddr    = '0;
        pwdata   = '0;
        in_valid = 1'b0;
        in_txn   = '0;
        sent     = 0;
        repeat (8) @(negedge clk);
        rst_n = 1'b1;
        #settle;
        assert (out_valid == 1'b0)
            else stop_on_error($sformatf("Error: reset_state out_valid expected 0 actual %0b",
                out_valid));
        assert (pslverr == 1'b0)
            else stop_on_error($sformatf("Error: reset_state pslverr expected 0 actual %0b",
                pslverr));
        @(negedge clk);

        fd = $fopen("tests/umi_remap_golden.txt", "r");
        assert (fd != 0) else stop_on_error("cannot open tests/umi_remap_golden.txt");
        while (!$feof(fd)) begin
            n = $fscanf(fd, "%s", op);
            if (n == 1) begin
                if (op.substr(0, 0) == "#") begin
                    void'($fgets(skip, fd));  // comment line
                end else begin
                    case (op)
                        "W": begin
                            drain_pipe();
                            n = $fscanf(fd, "%h %h", off, wdata);
                            assert (n == 2) else stop_on_error("malformed W line in golden file");
                            apb_access(1'b1, off, wdata, rdata, err);
                            assert (err == 1'b0)
                                else stop_on_error($sformatf(
                                    "Error: apb_write_%03h pslverr expected 0 actual %0b",
                                    off, err));
                        end
                        "R": begin
                            drain_pipe();
                            n = $fscanf(fd, "%h %h %h", off, exp_rdata, exp_err);
                            assert (n == 3) else stop_on_error("malformed R line in golden file");
                            apb_access(1'b0, off, '0, rdata, err);
                            assert (rdata == exp_rdata)
                                else stop_on_error($sformatf(
                                    "Error: apb_read_%03h prdata expected %h actual %h",
                                    off, exp_rdata, rdata));
                            assert (err == exp_err)
                                else stop_on_error($sformatf(
                                    "Error: apb_read_%03h pslverr expected %0b actual %0b",
                                    off, exp_err, err));
                        end
                        "T": begin
                            n = $fscanf(fd, "%s %h %h %h %h %h", name, cmd, dst, src, data,
                                        exp_dst);
                            assert (n == 6) else stop_on_error("malformed T line in golden file");
                            txn.cmd          = cmd;
                            txn.dstaddr.flat = dst;
                            txn.srcaddr      = src;
                            txn.data         = data;
                            exp_txn              = txn;  // only dstaddr may change
                            exp_txn.dstaddr.flat = exp_dst;
                            exp_q.push_back(exp_txn);
                            name_q.push_back(name);
                            sent++;
                            send_txn(txn);
                        end
                        default: stop_on_error($sformatf("unknown operation %s in golden file",
                                                         op));
                    endcase
                end
            end
        end
        $fclose(fd);
        drain_pipe();
        assert (sent > 0) else stop_on_error("golden file holds no transactions");
        // every expected transfer taken, nothing left behind in the output slot
        if (out_valid == 1'b0) begin
            $display("PASS: all tests");
            $finish;
        end else begin
            stop_on_error($sformatf("Error: end_of_run out_valid expected 0 actual %0b",
                out_valid));
        end
    end

endmodule
